// ==== vlog.f ====
source/pipe_pkg.sv
source/ex_mem_reg.sv
source/mem_apb_master.sv
source/apb_data_mem.sv
source/hazard_unit.sv
source/mem_wb_reg.sv
source/general_reg.sv
source/mem_wb_top.sv
testbench/tb_mem_wb_top.sv

// ==== Bender.yml ====
package:
  name: mem_wb_top

sources:
  - source/pipe_pkg.sv
  - source/ex_mem_reg.sv
  - source/mem_apb_master.sv
  - source/apb_data_mem.sv
  - source/hazard_unit.sv
  - source/mem_wb_reg.sv
  - source/general_reg.sv
  - source/mem_wb_top.sv
  - target: simulation
    files:
      - testbench/tb_mem_wb_top.sv

// ==== testbench/tb_mem_wb_top.sv ====
`timescale 1ns/10ps

module tb_mem_wb_top;

    localparam int ISSUE_TIMEOUT = 20;                  // cycles of back-pressure allowed per offer

    logic               clk;
    logic               rst_n;
    logic               issue_valid;
    logic               issue_ready;
    pipe_pkg::word_t    issue_alu_result;
    pipe_pkg::word_t    issue_store_data;
    pipe_pkg::reg_idx_t issue_dest_idx;
    logic               issue_reg_write;
    logic               issue_mem_read;
    logic               issue_mem_write;
    pipe_pkg::reg_idx_t rd_idx;
    pipe_pkg::word_t    rd_data;

    pipe_pkg::word_t    model_regs [pipe_pkg::REG_COUNT]; // reference register file
    pipe_pkg::word_t    model_mem [pipe_pkg::MEM_WORDS];  // reference data memory
    int                 error_count;
    int                 offer_count;                    // offers made by the stimulus
    int                 dut_accepts;                    // handshakes seen on the port
    logic               prev_was_mem;                   // last accept was a load or store
    logic               ready_known;                    // and it happened at the last edge

    mem_wb_top u_mem_wb_top (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            dut_accepts++;                              // counted apart from the stimulus
        end
    end

    task automatic compare_word(input pipe_pkg::word_t actual, expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_ready(input logic actual, expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic compare_count(input int actual, expected, input string what);
        if (actual != expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic finish_run;
        $display("offers %0d, accepted %0d, errors %0d", offer_count, dut_accepts, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // in-order architectural effect of one accepted instruction
    task automatic apply_model(input pipe_pkg::word_t alu, store, input pipe_pkg::reg_idx_t dest,
                               input logic rw, mr, mw);
        int idx;
        idx = int'((alu >> 2) % pipe_pkg::MEM_WORDS);   // word bits only, wraps on depth
        if (mw) begin
            model_mem[idx] = store;
        end else if (rw && dest != 0) begin
            model_regs[dest] = mr ? model_mem[idx] : alu;
        end
    endtask

    // byte address inside the lowest words, with byte offset and aliasing bits
    function automatic pipe_pkg::word_t random_addr(input int words);
        return pipe_pkg::word_t'(($urandom_range(words - 1, 0) << 2) | $urandom_range(3, 0) |
                                 ($urandom_range(3, 0) << 10));
    endfunction

    // called just after a rising edge, holds the offer until the handshake edge
    task automatic issue_instr(input pipe_pkg::word_t alu, store, input pipe_pkg::reg_idx_t dest,
                               input logic rw, mr, mw);
        int waited;
        waited = 0;
        issue_valid      <= 1'b1;
        issue_alu_result <= alu;
        issue_store_data <= store;
        issue_dest_idx   <= dest;
        issue_reg_write  <= rw;
        issue_mem_read   <= mr;
        issue_mem_write  <= mw;
        offer_count++;
        @(negedge clk);
        if (ready_known) begin
            compare_ready(issue_ready, !prev_was_mem, "issue_ready after an accept");
        end
        while (!issue_ready && waited < ISSUE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!issue_ready) begin
            error_count++;
            $display("issue_ready stayed low for %0d cycles, offer never taken", waited);
            finish_run;
        end else begin
            @(posedge clk);                             // handshake edge
            apply_model(alu, store, dest, rw, mr, mw);
            prev_was_mem = mr | mw;
            ready_known  = 1'b1;
        end
    endtask

    // idle issue slots carry junk fields that must never reach the register file
    task automatic idle_cycles(input int n);
        issue_valid      <= 1'b0;
        issue_reg_write  <= 1'b1;
        issue_mem_write  <= 1'($urandom_range(1, 0));
        issue_alu_result <= $urandom;
        @(negedge clk);
        if (ready_known) begin
            compare_ready(issue_ready, !prev_was_mem, "issue_ready after an accept");
        end
        ready_known = 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic check_all_regs(input string phase);
        for (int i = 0; i < pipe_pkg::REG_COUNT; i++) begin
            rd_idx <= pipe_pkg::reg_idx_t'(i);
            @(negedge clk);
            compare_word(rd_data, model_regs[i], $sformatf("%s r%0d", phase, i));
            @(posedge clk);
        end
    endtask

    initial begin
        pipe_pkg::reg_idx_t dest;
        void'($urandom(4));
        clk              = 1'b0;
        rst_n            = 1'b0;
        issue_valid      = 1'b0;
        issue_alu_result = '0;
        issue_store_data = '0;
        issue_dest_idx   = '0;
        issue_reg_write  = 1'b0;
        issue_mem_read   = 1'b0;
        issue_mem_write  = 1'b0;
        rd_idx           = '0;
        error_count      = 0;
        offer_count      = 0;
        dut_accepts      = 0;
        prev_was_mem     = 1'b0;
        ready_known      = 1'b1;
        for (int i = 0; i < pipe_pkg::REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < pipe_pkg::MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(1);                                 // ready high straight after reset
        check_all_regs("reset");
        for (int k = 0; k < 200; k++) begin             // alu traffic with idle slots
            if ($urandom_range(3, 0) == 0) begin
                idle_cycles($urandom_range(2, 1));
            end else begin
                issue_instr($urandom, $urandom, pipe_pkg::reg_idx_t'($urandom_range(31, 0)),
                            $urandom_range(4, 0) != 0, 1'b0, 1'b0);
            end
        end
        idle_cycles(10);
        check_all_regs("alu");
        for (int r = 0; r < 6; r++) begin               // stores to 12 words, loads from 16
            for (int k = 0; k < 20; k++) begin
                if ($urandom_range(1, 0) == 0) begin
                    issue_instr(random_addr(12), $urandom, '0, 1'b0, 1'b0, 1'b1);
                end else begin
                    issue_instr(random_addr(16), $urandom, pipe_pkg::reg_idx_t'(k + 1),
                                1'b1, 1'b1, 1'b0);
                end
            end
            idle_cycles(10);
            check_all_regs("load/store");
        end
        for (int w = 0; w < 16; w++) begin              // words 12..15 were never stored
            issue_instr(pipe_pkg::word_t'(w * 4), '0, pipe_pkg::reg_idx_t'(w + 1),
                        1'b1, 1'b1, 1'b0);
        end
        idle_cycles(10);
        check_all_regs("readback");
        for (int k = 0; k < 40; k++) begin              // load then alu to the same register
            dest = pipe_pkg::reg_idx_t'($urandom_range(31, 1));
            issue_instr(random_addr(16), $urandom, dest, 1'b1, 1'b1, 1'b0);
            issue_instr($urandom, $urandom, dest, 1'b1, 1'b0, 1'b0);
            if ($urandom_range(1, 0) == 1) begin
                issue_instr(random_addr(12), $urandom, dest, 1'b0, 1'b0, 1'b1);
            end
        end
        idle_cycles(10);
        check_all_regs("mixed");
        compare_count(dut_accepts, offer_count, "accepted instructions");
        finish_run;
    end

endmodule

// ==== source/mem_wb_top.sv ====
`timescale 1ns/10ps

module mem_wb_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,             // issue port from execute
    output logic               issue_ready,
    input  pipe_pkg::word_t    issue_alu_result,
    input  pipe_pkg::word_t    issue_store_data,
    input  pipe_pkg::reg_idx_t issue_dest_idx,
    input  logic               issue_reg_write,
    input  logic               issue_mem_read,
    input  logic               issue_mem_write,
    input  pipe_pkg::reg_idx_t rd_idx,                  // register read port
    output pipe_pkg::word_t    rd_data
);

    // memory stage
    logic                   mem_no_op;
    pipe_pkg::word_t        mem_alu_result;
    pipe_pkg::word_t        mem_store_data;
    pipe_pkg::reg_idx_t     mem_dest_idx;
    logic                   mem_reg_write;
    logic                   mem_mem_read;
    logic                   mem_mem_write;
    logic                   mem_busy;
    pipe_pkg::word_t        mem_read_data;

    // apb between the memory stage and the data memory
    pipe_pkg::mem_addr_t    paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    pipe_pkg::word_t        pwdata;
    pipe_pkg::word_t        prdata;
    logic                   pready;

    pipe_pkg::hazard_ctrl_t ex_hazard;
    pipe_pkg::hazard_ctrl_t wb_hazard;

    // write-back stage
    logic                   wb_no_op;
    logic                   wb_reg_write;
    logic                   wb_mem_read;
    pipe_pkg::word_t        wb_alu_result;
    pipe_pkg::word_t        wb_mem_read_data;
    pipe_pkg::reg_idx_t     wb_dest_idx;

    ex_mem_reg u_ex_mem_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .hazard           (ex_hazard),
        .issue_valid      (issue_valid),
        .issue_alu_result (issue_alu_result),
        .issue_store_data (issue_store_data),
        .issue_dest_idx   (issue_dest_idx),
        .issue_reg_write  (issue_reg_write),
        .issue_mem_read   (issue_mem_read),
        .issue_mem_write  (issue_mem_write),
        .mem_no_op        (mem_no_op),
        .mem_alu_result   (mem_alu_result),
        .mem_store_data   (mem_store_data),
        .mem_dest_idx     (mem_dest_idx),
        .mem_reg_write    (mem_reg_write),
        .mem_mem_read     (mem_mem_read),
        .mem_mem_write    (mem_mem_write)
    );

    mem_apb_master u_mem_apb_master (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_no_op      (mem_no_op),
        .mem_mem_read   (mem_mem_read),
        .mem_mem_write  (mem_mem_write),
        .mem_alu_result (mem_alu_result),
        .mem_store_data (mem_store_data),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .mem_busy       (mem_busy),
        .mem_read_data  (mem_read_data)
    );

    apb_data_mem u_apb_data_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    hazard_unit u_hazard_unit (
        .mem_busy    (mem_busy),
        .mem_no_op   (mem_no_op),
        .ex_hazard   (ex_hazard),
        .wb_hazard   (wb_hazard),
        .issue_ready (issue_ready)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .hazard           (wb_hazard),
        .mem_no_op        (mem_no_op),
        .wb_no_op         (wb_no_op),
        .mem_reg_write    (mem_reg_write),
        .wb_reg_write     (wb_reg_write),
        .mem_mem_read     (mem_mem_read),
        .wb_mem_read      (wb_mem_read),
        .mem_alu_result   (mem_alu_result),
        .wb_alu_result    (wb_alu_result),
        .mem_read_data    (mem_read_data),
        .wb_mem_read_data (wb_mem_read_data),
        .mem_dest_idx     (mem_dest_idx),
        .wb_dest_idx      (wb_dest_idx)
    );

    general_reg u_general_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .wb_no_op         (wb_no_op),
        .wb_reg_write     (wb_reg_write),
        .wb_mem_read      (wb_mem_read),
        .wb_alu_result    (wb_alu_result),
        .wb_mem_read_data (wb_mem_read_data),
        .wb_dest_idx      (wb_dest_idx),
        .rd_idx           (rd_idx),
        .rd_data          (rd_data)
    );

endmodule

// ==== source/general_reg.sv ====
`timescale 1ns/10ps

module general_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_no_op,                // bubble, no write
    input  logic               wb_reg_write,
    input  logic               wb_mem_read,             // load result instead of alu result
    input  pipe_pkg::word_t    wb_alu_result,
    input  pipe_pkg::word_t    wb_mem_read_data,
    input  pipe_pkg::reg_idx_t wb_dest_idx,
    input  pipe_pkg::reg_idx_t rd_idx,                  // combinational read port
    output pipe_pkg::word_t    rd_data
);

    pipe_pkg::word_t regs [pipe_pkg::REG_COUNT];
    pipe_pkg::word_t wr_data;
    logic            wr_en;

    // write-back select
    assign wr_data = wb_mem_read ? wb_mem_read_data : wb_alu_result;
    assign wr_en   = wb_reg_write & ~wb_no_op & (wb_dest_idx != '0); // r0 ignores writes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_dest_idx] <= wr_data;
        end
    end

    assign rd_data = (rd_idx == '0) ? '0 : regs[rd_idx]; // r0 always zero

endmodule

// ==== source/mem_wb_reg.sv ====
`timescale 1ns/10ps

module mem_wb_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_pkg::hazard_ctrl_t hazard,              // hold keeps data, no-op pauses wb
    input  logic                   mem_no_op,           // memory stage bubble
    output logic                   wb_no_op,            // blocks the register file write
    input  logic                   mem_reg_write,
    output logic                   wb_reg_write,
    input  logic                   mem_mem_read,
    output logic                   wb_mem_read,         // selects load data in general_reg
    input  pipe_pkg::word_t        mem_alu_result,
    output pipe_pkg::word_t        wb_alu_result,
    input  pipe_pkg::word_t        mem_read_data,       // captured by mem_apb_master
    output pipe_pkg::word_t        wb_mem_read_data,
    input  pipe_pkg::reg_idx_t     mem_dest_idx,
    output pipe_pkg::reg_idx_t     wb_dest_idx
);

    logic hold;

    assign hold = hazard[pipe_pkg::HAZD_HOLD_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_no_op     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
        end else begin
            wb_reg_write <= mem_reg_write;              // tracks the stage, no_op guards it when held
            if (!hold) begin
                wb_mem_read <= mem_mem_read;
            end
            if (hazard == pipe_pkg::RESUME) begin
                wb_no_op <= 1'b0;
            end else begin
                wb_no_op <= hazard[pipe_pkg::HAZD_NO_OP_BIT] | mem_no_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_alu_result    <= mem_alu_result;
            wb_mem_read_data <= mem_read_data;
            wb_dest_idx      <= mem_dest_idx;
        end
    end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic                   mem_busy,            // apb transfer still running
    input  logic                   mem_no_op,           // memory stage is a bubble
    output pipe_pkg::hazard_ctrl_t ex_hazard,           // to ex_mem_reg
    output pipe_pkg::hazard_ctrl_t wb_hazard,           // to mem_wb_reg
    output logic                   issue_ready          // back-pressure to the execute side
);

    logic stall;                                        // live memory instruction in flight

    assign stall       = mem_busy & ~mem_no_op;
    assign issue_ready = ~stall;

    always_comb begin
        ex_hazard = pipe_pkg::RESUME;
        wb_hazard = pipe_pkg::RESUME;
        if (stall) begin
            ex_hazard[pipe_pkg::HAZD_HOLD_BIT]  = 1'b1; // keep the load/store in place
            wb_hazard[pipe_pkg::HAZD_HOLD_BIT]  = 1'b1;
            wb_hazard[pipe_pkg::HAZD_NO_OP_BIT] = 1'b1; // write-back sees bubbles
        end
    end

endmodule

// ==== source/apb_data_mem.sv ====
`timescale 1ns/10ps

module apb_data_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::mem_addr_t paddr,                  // byte address, word bits select
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  pipe_pkg::word_t     pwdata,
    output pipe_pkg::word_t     prdata,
    output logic                pready                  // low on the first access cycle
);

    pipe_pkg::word_t    mem [pipe_pkg::MEM_WORDS];
    pipe_pkg::mem_idx_t word_idx;
    logic               access_phase;

    assign word_idx     = paddr[2 +: pipe_pkg::MEM_IDX_WIDTH]; // wraps modulo the depth
    assign access_phase = psel & penable;

    // one wait state, pready rises for the second access cycle only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready <= 1'b0;
        end else begin
            pready <= access_phase & ~pready;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pipe_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (access_phase && pready && pwrite) begin
            mem[word_idx] <= pwdata;                    // write lands on the completing edge
        end
    end

    // read word is fetched during the wait state and shown with pready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prdata <= '0;
        end else if (access_phase && !pready && !pwrite) begin
            prdata <= mem[word_idx];
        end
    end

endmodule

// ==== source/mem_apb_master.sv ====
`timescale 1ns/10ps

module mem_apb_master (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_no_op,              // from ex_mem_reg
    input  logic                mem_mem_read,
    input  logic                mem_mem_write,
    input  pipe_pkg::word_t     mem_alu_result,         // used as the byte address
    input  pipe_pkg::word_t     mem_store_data,
    output pipe_pkg::mem_addr_t paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output pipe_pkg::word_t     pwdata,
    input  pipe_pkg::word_t     prdata,
    input  logic                pready,
    output logic                mem_busy,               // to hazard_unit, stage must freeze
    output pipe_pkg::word_t     mem_read_data           // captured load data for mem_wb_reg
);

    pipe_pkg::apb_state_t state_q;                      // registered bus state
    pipe_pkg::apb_state_t phase;                        // phase actually driven this cycle
    pipe_pkg::apb_state_t state_next;
    logic                 live_access;                  // real load or store in the stage
    logic                 start;
    logic                 complete;                     // last access cycle, pready seen
    logic                 done_q;                       // transfer of the held instruction finished

    assign live_access = ~mem_no_op & (mem_mem_read | mem_mem_write);
    assign start       = live_access & ~done_q;
    assign mem_busy    = live_access & ~done_q;         // through the completing cycle

    always_comb begin
        phase = state_q;
        if (state_q == pipe_pkg::APB_IDLE && start) begin
            phase = pipe_pkg::APB_SETUP;                // setup in the first stage cycle
        end
    end

    always_comb begin
        case (phase)
            pipe_pkg::APB_SETUP:  state_next = pipe_pkg::APB_ACCESS;
            pipe_pkg::APB_ACCESS: state_next = pready ? pipe_pkg::APB_IDLE : pipe_pkg::APB_ACCESS;
            default:              state_next = pipe_pkg::APB_IDLE;
        endcase
    end

    assign psel     = (phase != pipe_pkg::APB_IDLE);
    assign penable  = (phase == pipe_pkg::APB_ACCESS);
    assign complete = penable & pready;
    assign paddr    = mem_alu_result;                   // stable, stage is held during the transfer
    assign pwrite   = mem_mem_write;
    assign pwdata   = mem_store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pipe_pkg::APB_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_next;
            done_q  <= complete;                        // stage always advances one cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (complete && !pwrite) begin
            mem_read_data <= prdata;
        end
    end

endmodule

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/10ps

module ex_mem_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_pkg::hazard_ctrl_t hazard,              // from hazard_unit
    input  logic                   issue_valid,         // offer from the execute side
    input  pipe_pkg::word_t        issue_alu_result,
    input  pipe_pkg::word_t        issue_store_data,
    input  pipe_pkg::reg_idx_t     issue_dest_idx,
    input  logic                   issue_reg_write,
    input  logic                   issue_mem_read,
    input  logic                   issue_mem_write,
    output logic                   mem_no_op,           // bubble in the memory stage
    output pipe_pkg::word_t        mem_alu_result,      // also the load/store address
    output pipe_pkg::word_t        mem_store_data,
    output pipe_pkg::reg_idx_t     mem_dest_idx,
    output logic                   mem_reg_write,
    output logic                   mem_mem_read,
    output logic                   mem_mem_write
);

    logic capture_op;                                   // a live instruction is taken this edge

    assign capture_op = issue_valid & ~hazard[pipe_pkg::HAZD_NO_OP_BIT];

    // control fields, cleared so an empty slot never writes or touches memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_no_op     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else if (!hazard[pipe_pkg::HAZD_HOLD_BIT]) begin
            mem_no_op     <= ~capture_op;               // idle issue cycle enters as a bubble
            mem_reg_write <= capture_op & issue_reg_write;
            mem_mem_read  <= capture_op & issue_mem_read;
            mem_mem_write <= capture_op & issue_mem_write;
        end
    end

    // payload, frozen together with the control fields while held
    always_ff @(posedge clk) begin
        if (!hazard[pipe_pkg::HAZD_HOLD_BIT]) begin
            mem_alu_result <= issue_alu_result;
            mem_store_data <= issue_store_data;
            mem_dest_idx   <= issue_dest_idx;
        end
    end

endmodule

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

    localparam int WORD_WIDTH    = 32;                  // datapath word
    localparam int ADDR_WIDTH    = 32;                  // apb byte address
    localparam int REG_IDX_WIDTH = 5;
    localparam int REG_COUNT     = 32;                  // general registers, r0 hardwired to zero
    localparam int MEM_WORDS     = 256;                 // data memory depth in words
    localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);

    // bit positions inside a hazard control vector
    localparam int HAZD_HOLD_BIT  = 0;                  // stage register keeps its contents
    localparam int HAZD_NO_OP_BIT = 1;                  // next stage sees a bubble

    typedef logic [WORD_WIDTH-1:0]    word_t;           // alu result, store or load data
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;        // register file index
    typedef logic [ADDR_WIDTH-1:0]    mem_addr_t;       // byte address on apb
    typedef logic [MEM_IDX_WIDTH-1:0] mem_idx_t;        // word index inside the data memory
    typedef logic [1:0]               hazard_ctrl_t;    // {no_op, hold}

    localparam hazard_ctrl_t RESUME = 2'b00;            // normal flow, clears no-op

    typedef enum logic [1:0] {
        APB_IDLE,                                       // no transfer on the bus
        APB_SETUP,                                      // psel high, penable low
        APB_ACCESS                                      // psel and penable high until pready
    } apb_state_t;

endpackage
